// ==== hw/srf_cfg_pkg.sv ====
// Sizes and plain vector types shared by every stage of the serial
// register file engine.
package srf_cfg_pkg;

   // Number of architectural registers, x0 included.
   localparam int REG_COUNT = 32;

   // Width of one register in bits.
   // This is also the number of bit steps in one command.
   localparam int XLEN = 32;

   // Width of the APB byte address seen by the register block.
   localparam int PADDR_W = 4;

   // A register number, x0 to x31.
   typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

   // A bit position inside a register.
   // It also selects one row of the transposed storage.
   typedef logic [$clog2(XLEN)-1:0] bit_idx_t;

   // One full data word, as seen by the host.
   typedef logic [XLEN-1:0] word_t;

   // APB byte address.
   typedef logic [PADDR_W-1:0] paddr_t;

endpackage

// ==== hw/srf_cmd_pkg.sv ====
// Command encoding, APB register map and the structs that travel
// between the pipeline stages.
package srf_cmd_pkg;
   import srf_cfg_pkg::*;

   // Operation codes as written in the top bits of the CMD register.
   // Codes 6 and 7 are unused and behave like PASS.
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_PASS = 3'd5
   } op_e;

   // A command, 19 bits.
   // In the CMD register it sits in the low bits, LSB first:
   // rs2 at [4:0], rs1 at [9:5], rd at [14:10], use_imm at [15] and op at [18:16].
   typedef struct packed {
      op_e      op;
      logic     use_imm;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
   } cmd_s;

   // One bit step issued by the sequencer.
   typedef struct packed {
      logic     valid;
      logic     last;
      bit_idx_t bit_idx;
      cmd_s     cmd;
   } step_s;

   // One operand step, a being the rs1 bit and b the rs2 or immediate bit.
   typedef struct packed {
      logic     valid;
      logic     last;
      bit_idx_t bit_idx;
      logic     a;
      logic     b;
      cmd_s     cmd;
   } opnd_s;

   // One single-bit writeback into the storage.
   typedef struct packed {
      logic     en;
      reg_idx_t rd;
      bit_idx_t bit_idx;
      logic     data;
   } wb_s;

   // Register offsets. STATUS holds busy in bit 0 and done in bit 1.
   localparam paddr_t ADDR_IMM    = 4'h0;
   localparam paddr_t ADDR_CMD    = 4'h4;
   localparam paddr_t ADDR_STATUS = 4'h8;
   localparam paddr_t ADDR_RESULT = 4'hC;

endpackage

// ==== hw/srf_apb_regs.sv ====
`timescale 1ns/1ps

// APB slave of the engine.
// It holds the immediate and the command, starts the sequencer and keeps
// the result word and the done flag for the host.
module srf_apb_regs (
   input  logic                i_clk,
   input  logic                i_reset,
   input  logic                i_psel,
   input  logic                i_penable,
   input  logic                i_pwrite,
   input  srf_cfg_pkg::paddr_t i_paddr,
   input  srf_cfg_pkg::word_t  i_pwdata,
   output srf_cfg_pkg::word_t  o_prdata,
   output logic                o_pready,
   output logic                o_pslverr,
   input  logic                i_busy,
   input  logic                i_done,
   input  srf_cfg_pkg::word_t  i_result,
   output logic                o_start,
   output srf_cmd_pkg::cmd_s   o_cmd,
   output srf_cfg_pkg::word_t  o_imm
);
   import srf_cfg_pkg::*;
   import srf_cmd_pkg::*;

   localparam int CMD_W = $bits(cmd_s);

   logic  wr_access;
   logic  rd_access;
   logic  cmd_wr;
   logic  cmd_ok;
   logic  engine_busy;
   logic  done_q;
   word_t result_q;

   // The access phase is the second cycle of a transfer.
   // With pready tied high every transfer ends there.
   assign wr_access = i_psel & i_penable & i_pwrite;
   assign rd_access = i_psel & i_penable & ~i_pwrite;

   // The start pulse counts as busy too.
   // The sequencer only raises busy on the cycle after it.
   assign engine_busy = i_busy | o_start;

   assign cmd_wr = wr_access && (i_paddr == ADDR_CMD);
   assign cmd_ok = cmd_wr & ~engine_busy;

   assign o_pready  = 1'b1;
   assign o_pslverr = cmd_wr & engine_busy;

   // The immediate is sampled bit by bit while the command runs.
   always_ff @(posedge i_clk) begin
      if (wr_access && (i_paddr == ADDR_IMM)) begin
         o_imm <= i_pwdata;
      end
   end

   // A refused CMD write leaves the previous command in place.
   always_ff @(posedge i_clk) begin
      if (cmd_ok) begin
         o_cmd <= cmd_s'(i_pwdata[CMD_W-1:0]);
      end
   end

   // The whole result word is presented together with i_done.
   always_ff @(posedge i_clk) begin
      if (i_done) begin
         result_q <= i_result;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_start <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         o_start <= cmd_ok;
         // A finishing command wins over a STATUS read in the same cycle.
         if (i_done) begin
            done_q <= 1'b1;
         end else if (cmd_ok || (rd_access && (i_paddr == ADDR_STATUS))) begin
            done_q <= 1'b0;
         end
      end
   end

   // Read data is a plain decode of the registers.
   // Unmapped offsets return zero.
   always_comb begin
      case (i_paddr)
         ADDR_IMM:    o_prdata = o_imm;
         ADDR_CMD:    o_prdata = {{(XLEN - CMD_W){1'b0}}, o_cmd};
         ADDR_STATUS: o_prdata = {{(XLEN - 2){1'b0}}, done_q, engine_busy};
         ADDR_RESULT: o_prdata = result_q;
         default:     o_prdata = '0;
      endcase
   end

endmodule

// ==== hw/srf_sequencer.sv ====
`timescale 1ns/1ps

// Control FSM of the engine.
// After a start it issues one bit step per cycle, bit 0 first, and
// stays busy for one more cycle while the last bit drains through the ALU.
module srf_sequencer (
   input  logic               i_clk,
   input  logic               i_reset,
   input  logic               i_start,
   input  srf_cmd_pkg::cmd_s  i_cmd,
   output logic               o_busy,
   output srf_cmd_pkg::step_s o_step
);
   import srf_cfg_pkg::*;
   import srf_cmd_pkg::*;

   typedef enum logic {
      IDLE,
      RUN
   } state_e;

   localparam bit_idx_t LAST_BIT = bit_idx_t'(XLEN - 1);

   state_e   state_q;
   bit_idx_t cnt_q;
   logic     step_en_q;
   cmd_s     cmd_q;

   // RUN covers the step cycles plus one drain cycle.
   // The drain cycle is recognised by step_en_q being low.
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state_q   <= IDLE;
         cnt_q     <= '0;
         step_en_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (i_start) begin
                  state_q   <= RUN;
                  cnt_q     <= '0;
                  step_en_q <= 1'b1;
               end
            end
            RUN: begin
               if (!step_en_q) begin
                  state_q <= IDLE;
               end else if (cnt_q == LAST_BIT) begin
                  step_en_q <= 1'b0;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
         endcase
      end
   end

   // The command is copied once, so the host may not disturb it later.
   always_ff @(posedge i_clk) begin
      if ((state_q == IDLE) && i_start) begin
         cmd_q <= i_cmd;
      end
   end

   assign o_busy = (state_q == RUN);

   always_comb begin
      o_step.valid   = step_en_q;
      o_step.last    = step_en_q && (cnt_q == LAST_BIT);
      o_step.bit_idx = cnt_q;
      o_step.cmd     = cmd_q;
   end

endmodule

// ==== hw/srf_bit_ram.sv ====
`timescale 1ns/1ps

// Transposed register storage.
// Row k holds bit k of every register, so one row read gives the current
// bit of both source operands at once.
module srf_bit_ram #(
   parameter int REG_COUNT = srf_cfg_pkg::REG_COUNT
) (
   input  logic               i_clk,
   input  srf_cmd_pkg::step_s i_step,
   input  srf_cfg_pkg::word_t i_imm,
   input  srf_cmd_pkg::wb_s   i_wb,
   output srf_cmd_pkg::opnd_s o_opnd
);
   import srf_cfg_pkg::*;
   import srf_cmd_pkg::*;

   logic [REG_COUNT-1:0] mem [XLEN];
   logic [REG_COUNT-1:0] row_q;
   logic [REG_COUNT-1:0] wr_mask;
   logic                 imm_bit_q;
   step_s                step_q;

   // Only the rd column is writable, and never column 0.
   // Storage for x0 therefore keeps whatever it powers up with.
   always_comb begin
      wr_mask          = '0;
      wr_mask[i_wb.rd] = i_wb.en;
      wr_mask[0]       = 1'b0;
   end

   always_ff @(posedge i_clk) begin
      for (int r = 0; r < REG_COUNT; r++) begin
         if (wr_mask[r]) begin
            mem[i_wb.bit_idx][r] <= i_wb.data;
         end
      end
   end

   // Row k is read in the step cycle and written one cycle later.
   // So rd may equal rs1 or rs2 and still see the old bit.
   always_ff @(posedge i_clk) begin
      row_q     <= mem[i_step.bit_idx];
      imm_bit_q <= i_imm[i_step.bit_idx];
      step_q    <= i_step;
   end

   // Operand select from the registered row.
   // x0 is forced to zero here rather than in the storage.
   always_comb begin
      o_opnd.valid   = step_q.valid;
      o_opnd.last    = step_q.last;
      o_opnd.bit_idx = step_q.bit_idx;
      o_opnd.cmd     = step_q.cmd;
      o_opnd.a       = (step_q.cmd.rs1 != '0) ? row_q[step_q.cmd.rs1] : 1'b0;
      if (step_q.cmd.use_imm) begin
         o_opnd.b = imm_bit_q;
      end else begin
         o_opnd.b = (step_q.cmd.rs2 != '0) ? row_q[step_q.cmd.rs2] : 1'b0;
      end
   end

endmodule

// ==== hw/srf_serial_alu.sv ====
`timescale 1ns/1ps

// One-bit ALU.
// Each cycle it takes one operand bit pair, returns the result bit as a
// writeback and shifts the same bit into the result word from the top.
module srf_serial_alu #(
   parameter int XLEN = srf_cfg_pkg::XLEN
) (
   input  logic               i_clk,
   input  logic               i_reset,
   input  srf_cmd_pkg::opnd_s i_opnd,
   output srf_cmd_pkg::wb_s   o_wb,
   output srf_cfg_pkg::word_t o_result,
   output logic               o_done
);
   import srf_cmd_pkg::*;

   logic            is_sub;
   logic            b_eff;
   logic            cin;
   logic            sum;
   logic            cout;
   logic            res_bit;
   logic            carry_q;
   logic [XLEN-1:0] res_q;
   logic [XLEN-1:0] res_d;

   // SUB is a + ~b + 1, with the +1 coming in as carry on bit 0.
   // On later bits the carry comes from the register.
   always_comb begin
      is_sub = (i_opnd.cmd.op == OP_SUB);
      b_eff  = i_opnd.b ^ is_sub;
      cin    = (i_opnd.bit_idx == '0) ? is_sub : carry_q;
      sum    = i_opnd.a ^ b_eff ^ cin;
      cout   = (i_opnd.a & b_eff) | (cin & (i_opnd.a ^ b_eff));
      case (i_opnd.cmd.op)
         OP_ADD, OP_SUB: res_bit = sum;
         OP_AND:         res_bit = i_opnd.a & i_opnd.b;
         OP_OR:          res_bit = i_opnd.a | i_opnd.b;
         OP_XOR:         res_bit = i_opnd.a ^ i_opnd.b;
         // PASS, loads with use_imm and copies rs1 otherwise.
         default:        res_bit = i_opnd.cmd.use_imm ? i_opnd.b : i_opnd.a;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         carry_q <= 1'b0;
      end else if (i_opnd.valid) begin
         carry_q <= cout;
      end
   end

   // The word after this cycle's shift.
   // On the last bit it is already the complete result.
   assign res_d = i_opnd.valid ? {res_bit, res_q[XLEN-1:1]} : res_q;

   always_ff @(posedge i_clk) begin
      res_q <= res_d;
   end

   assign o_result = res_d;
   assign o_done   = i_opnd.valid & i_opnd.last;

   always_comb begin
      o_wb.en      = i_opnd.valid;
      o_wb.rd      = i_opnd.cmd.rd;
      o_wb.bit_idx = i_opnd.bit_idx;
      o_wb.data    = res_bit;
   end

endmodule

// ==== hw/srf_top.sv ====
`timescale 1ns/1ps

// Top level of the bit-serial register file engine.
// Host writes go through the APB block, and the three pipeline stages
// then stream one bit per cycle through storage and ALU.
module srf_top #(
   parameter int REG_COUNT = srf_cfg_pkg::REG_COUNT,
   parameter int XLEN      = srf_cfg_pkg::XLEN
) (
   input  logic                i_clk,
   input  logic                i_reset,
   input  logic                i_psel,
   input  logic                i_penable,
   input  logic                i_pwrite,
   input  srf_cfg_pkg::paddr_t i_paddr,
   input  srf_cfg_pkg::word_t  i_pwdata,
   output srf_cfg_pkg::word_t  o_prdata,
   output logic                o_pready,
   output logic                o_pslverr
);
   import srf_cfg_pkg::*;
   import srf_cmd_pkg::*;

   logic  start;
   logic  busy;
   logic  done;
   cmd_s  cmd;
   word_t imm;
   word_t result;
   step_s step;
   opnd_s opnd;
   wb_s   wb;

   srf_apb_regs u_apb_regs (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr),
      .i_busy    (busy),
      .i_done    (done),
      .i_result  (result),
      .o_start   (start),
      .o_cmd     (cmd),
      .o_imm     (imm)
   );

   srf_sequencer u_sequencer (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_start (start),
      .i_cmd   (cmd),
      .o_busy  (busy),
      .o_step  (step)
   );

   // The writeback loops back from the ALU into the storage.
   srf_bit_ram #(
      .REG_COUNT (REG_COUNT)
   ) u_bit_ram (
      .i_clk  (i_clk),
      .i_step (step),
      .i_imm  (imm),
      .i_wb   (wb),
      .o_opnd (opnd)
   );

   srf_serial_alu #(
      .XLEN (XLEN)
   ) u_serial_alu (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_opnd   (opnd),
      .o_wb     (wb),
      .o_result (result),
      .o_done   (done)
   );

endmodule

// ==== sim/srf_checker.sv ====
`timescale 1ns/1ps

// Protocol checks on a stream of bit beats.
// One copy watches the sequencer steps, another the ALU writebacks.
module srf_checker #(
   parameter int XLEN = srf_cfg_pkg::XLEN
) (
   input logic i_clk,
   input logic i_reset,
   input logic i_valid,
   input logic i_last,
   input logic i_flag,
   input logic i_active
);
   int unsigned run_q;

   // Length of the current run of valid beats.
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         run_q <= 0;
      end else if (i_valid) begin
         run_q <= run_q + 1;
      end else begin
         run_q <= 0;
      end
   end

   // A run ends after exactly one beat per register bit.
   a_burst_len: assert property (@(posedge i_clk) disable iff (i_reset)
      $fell(i_valid) |-> (run_q == XLEN))
      else $error("Beat run ended after %0d cycles instead of %0d", run_q, XLEN);

   // No run grows past one register width.
   a_burst_max: assert property (@(posedge i_clk) disable iff (i_reset)
      i_valid |-> (run_q < XLEN))
      else $error("Beat run is longer than %0d cycles", XLEN);

   // The final beat of a run is marked last and comes with its companion flag.
   a_last_flag: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_valid && (run_q == XLEN - 1)) |-> (i_last && i_flag))
      else $error("Final beat of a run seen without its last mark or flag");

   // Nothing moves while the stage is idle.
   a_idle: assert property (@(posedge i_clk) disable iff (i_reset)
      !i_active |-> !i_valid)
      else $error("Beat seen while the engine is idle");

endmodule

// On the sequencer the last step must carry bit 31 and busy must be high.
bind srf_sequencer srf_checker #(.XLEN(srf_cfg_pkg::XLEN)) u_step_chk (
   .i_clk    (i_clk),
   .i_reset  (i_reset),
   .i_valid  (o_step.valid),
   .i_last   (o_step.last),
   .i_flag   (&o_step.bit_idx),
   .i_active (o_busy)
);

// On the ALU the writeback of bit 31 must raise done.
// Writebacks are only allowed while the sequencer reports busy.
bind srf_serial_alu srf_checker #(.XLEN(XLEN)) u_wb_chk (
   .i_clk    (i_clk),
   .i_reset  (i_reset),
   .i_valid  (o_wb.en),
   .i_last   (&o_wb.bit_idx),
   .i_flag   (o_done),
   .i_active (u_sequencer.o_busy)
);

// ==== sim/srf_tb.sv ====
`timescale 1ns/1ps

// Testbench for the bit-serial register file engine.
// A table of commands is applied over APB, and every result is compared
// with a word-level model of the 32 registers.
module srf_tb;
   import srf_cfg_pkg::*;
   import srf_cmd_pkg::*;

   localparam int POLL_LIMIT   = 100;
   localparam int PREADY_LIMIT = 10;

   // One table row. The expected result comes from the model at run time.
   typedef struct packed {
      cmd_s  cmd;
      word_t imm;
   } vec_s;

   logic   clk;
   logic   reset;
   logic   psel;
   logic   penable;
   logic   pwrite;
   paddr_t paddr;
   word_t  pwdata;
   word_t  prdata;
   logic   pready;
   logic   pslverr;
   word_t  rd_data;
   word_t  model [REG_COUNT];
   vec_s   table_q [$];

   srf_top #(
      .REG_COUNT (REG_COUNT),
      .XLEN      (XLEN)
   ) srf_top_i (
      .i_clk     (clk),
      .i_reset   (reset),
      .i_psel    (psel),
      .i_penable (penable),
      .i_pwrite  (pwrite),
      .i_paddr   (paddr),
      .i_pwdata  (pwdata),
      .o_prdata  (prdata),
      .o_pready  (pready),
      .o_pslverr (pslverr)
   );

   always #2 clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   // One APB transfer, driven on falling edges.
   // PSLVERR and PRDATA are sampled 1 ns into the access phase.
   task automatic apb_xfer(input logic wr, input paddr_t addr, input word_t data,
                           input logic exp_err);
      int n;
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      n = 0;
      while (!pready) begin
         n++;
         assert (n < PREADY_LIMIT) else stop_on_error("APB transfer never saw PREADY");
         @(negedge clk);
         #1;
      end
      assert (pslverr == exp_err) else
         stop_on_error($sformatf("Mismatch o_pslverr at 0x%0h: got 0x%0h expected 0x%0h",
                                 addr, pslverr, exp_err));
      rd_data = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Polls STATUS until done is set. The read also clears done.
   task automatic wait_done();
      int n;
      n = 0;
      rd_data = '0;
      while (!rd_data[1]) begin
         n++;
         assert (n <= POLL_LIMIT) else stop_on_error("Timeout waiting for done in STATUS");
         apb_xfer(1'b0, ADDR_STATUS, '0, 1'b0);
      end
   endtask

   function automatic vec_s make_entry(input op_e op, input logic use_imm, input int rd,
                                       input int rs1, input int rs2, input word_t imm);
      vec_s v;
      v.cmd.op      = op;
      v.cmd.use_imm = use_imm;
      v.cmd.rd      = reg_idx_t'(rd);
      v.cmd.rs1     = reg_idx_t'(rs1);
      v.cmd.rs2     = reg_idx_t'(rs2);
      v.imm         = imm;
      return v;
   endfunction

   // Word-level reference of one command, with arithmetic modulo 2^32.
   function automatic word_t expect_result(input vec_s v);
      word_t a;
      word_t b;
      a = model[v.cmd.rs1];
      b = v.cmd.use_imm ? v.imm : model[v.cmd.rs2];
      case (v.cmd.op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         default: return v.cmd.use_imm ? v.imm : a;
      endcase
   endfunction

   // Runs one command and checks RESULT against the model.
   task automatic run_entry(input vec_s v);
      word_t exp;
      exp = expect_result(v);
      apb_xfer(1'b1, ADDR_IMM, v.imm, 1'b0);
      apb_xfer(1'b1, ADDR_CMD, word_t'(v.cmd), 1'b0);
      wait_done();
      apb_xfer(1'b0, ADDR_RESULT, '0, 1'b0);
      assert (rd_data == exp) else
         stop_on_error($sformatf(
            "Mismatch o_prdata (RESULT) for op %s rd x%0d: got 0x%08h expected 0x%08h",
            v.cmd.op.name(), v.cmd.rd, rd_data, exp));
      // x0 stays zero in the model.
      if (v.cmd.rd != '0) begin
         model[v.cmd.rd] = exp;
      end
   endtask

   // A second CMD write during a run must fail and leave the first command alone.
   task automatic check_busy_refusal();
      vec_s  first;
      vec_s  refused;
      word_t exp;
      first   = make_entry(OP_ADD, 1'b0, 10, 1, 2, 32'h0);
      refused = make_entry(OP_PASS, 1'b1, 11, 0, 0, 32'h0);
      exp     = expect_result(first);
      apb_xfer(1'b1, ADDR_IMM, first.imm, 1'b0);
      apb_xfer(1'b1, ADDR_CMD, word_t'(first.cmd), 1'b0);
      apb_xfer(1'b1, ADDR_CMD, word_t'(refused.cmd), 1'b1);
      apb_xfer(1'b0, ADDR_CMD, '0, 1'b0);
      assert (rd_data == word_t'(first.cmd)) else
         stop_on_error($sformatf("Mismatch o_prdata (CMD): got 0x%08h expected 0x%08h",
                                 rd_data, word_t'(first.cmd)));
      wait_done();
      // The poll that saw done has cleared it, and the engine is idle again.
      apb_xfer(1'b0, ADDR_STATUS, '0, 1'b0);
      assert (rd_data == '0) else
         stop_on_error($sformatf("Mismatch o_prdata (STATUS): got 0x%08h expected 0x0",
                                 rd_data));
      apb_xfer(1'b0, ADDR_RESULT, '0, 1'b0);
      assert (rd_data == exp) else
         stop_on_error($sformatf(
            "Mismatch o_prdata (RESULT) after refusal: got 0x%08h expected 0x%08h",
            rd_data, exp));
      model[10] = exp;
   endtask

   task automatic build_table();
      // Load every register, then read each one back through x0.
      for (int i = 1; i < REG_COUNT; i++) begin
         table_q.push_back(make_entry(OP_PASS, 1'b1, i, 0, 0, $urandom()));
      end
      for (int i = 1; i < REG_COUNT; i++) begin
         table_q.push_back(make_entry(OP_PASS, 1'b0, 0, i, 0, 32'h0));
      end
      // Carry chains across all 32 bits, and 0 minus 1.
      table_q.push_back(make_entry(OP_PASS, 1'b1, 1, 0, 0, 32'hFFFF_FFFF));
      table_q.push_back(make_entry(OP_PASS, 1'b1, 2, 0, 0, 32'h0000_0001));
      table_q.push_back(make_entry(OP_PASS, 1'b1, 3, 0, 0, 32'h8000_0000));
      table_q.push_back(make_entry(OP_ADD, 1'b0, 4, 1, 2, 32'h0));
      table_q.push_back(make_entry(OP_ADD, 1'b0, 5, 3, 3, 32'h0));
      table_q.push_back(make_entry(OP_SUB, 1'b0, 6, 0, 2, 32'h0));
      table_q.push_back(make_entry(OP_SUB, 1'b0, 7, 2, 1, 32'h0));
      table_q.push_back(make_entry(OP_ADD, 1'b1, 8, 1, 0, $urandom()));
      table_q.push_back(make_entry(OP_SUB, 1'b1, 9, 3, 0, $urandom()));
      // Bitwise operations on random words.
      table_q.push_back(make_entry(OP_PASS, 1'b1, 12, 0, 0, $urandom()));
      table_q.push_back(make_entry(OP_PASS, 1'b1, 13, 0, 0, $urandom()));
      table_q.push_back(make_entry(OP_AND, 1'b0, 14, 12, 13, 32'h0));
      table_q.push_back(make_entry(OP_OR, 1'b0, 15, 12, 13, 32'h0));
      table_q.push_back(make_entry(OP_XOR, 1'b0, 16, 12, 13, 32'h0));
      table_q.push_back(make_entry(OP_AND, 1'b1, 19, 13, 0, $urandom()));
      // A write to x0 is dropped, and x0 reads as zero.
      table_q.push_back(make_entry(OP_PASS, 1'b1, 0, 0, 0, 32'hDEAD_BEEF));
      table_q.push_back(make_entry(OP_PASS, 1'b0, 17, 0, 0, 32'h0));
      table_q.push_back(make_entry(OP_ADD, 1'b0, 18, 0, 13, 32'h0));
      // Same register as rd, rs1 and rs2 uses the old value.
      table_q.push_back(make_entry(OP_ADD, 1'b0, 13, 13, 13, 32'h0));
      table_q.push_back(make_entry(OP_XOR, 1'b0, 12, 12, 12, 32'h0));
      table_q.push_back(make_entry(OP_PASS, 1'b0, 0, 13, 0, 32'h0));
   endtask

   // Absolute limit on the whole run.
   initial begin
      #200000;
      stop_on_error("Simulation did not finish within 200 us");
   end

   initial begin
      void'($urandom(76));
      clk     = 1'b0;
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      rd_data = '0;
      foreach (model[r]) begin
         model[r] = '0;
      end
      build_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      foreach (table_q[k]) begin
         run_entry(table_q[k]);
      end
      check_busy_refusal();
      // The refused command's rd must still hold its old value.
      run_entry(make_entry(OP_PASS, 1'b0, 0, 11, 0, 32'h0));
      run_entry(make_entry(OP_PASS, 1'b0, 0, 10, 0, 32'h0));
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== serial_rf.f ====
hw/srf_cfg_pkg.sv
hw/srf_cmd_pkg.sv
hw/srf_apb_regs.sv
hw/srf_sequencer.sv
hw/srf_bit_ram.sv
hw/srf_serial_alu.sv
hw/srf_top.sv
sim/srf_checker.sv
sim/srf_tb.sv

// ==== Makefile ====
# Verilator build and run of the serial register file testbench.
VERILATOR ?= verilator
TOP       ?= srf_tb
FILELIST  ?= serial_rf.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST OK

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
